// ==== cpu_dispatch_pkg.sv ====
package cpu_dispatch_pkg;

  // external memory address width
  localparam int addr_size = 32;

  // data word width and cpu index word width
  localparam int data_size = 32;

  // width of a message code coming from a cpu
  localparam int cpu_msg_size = 8;

  // cpu became active
  localparam logic [cpu_msg_size-1:0] cpu_r_start = 8'h01;
  // cpu went idle
  localparam logic [cpu_msg_size-1:0] cpu_r_end = 8'h02;

  // flag positions in the cpu index word
  // active bit set means low bits carry the number of an active cpu
  localparam int cpu_active_bit = 31;
  // nonactive bit alone is the wake slot for any idle cpu
  localparam int cpu_nonactive_bit = 30;

  // wait cycles before a silent memory is given up on
  localparam int mem_timeout_default = 50;

  // dispatcher control states
  typedef enum logic [2:0] {
    // poll and bus request check
    loop       = 3'd0,
    // polled cpu gets its chance to talk
    cpu_cmd    = 3'd1,
    // memory operation in flight
    mem_work   = 3'd2,
    // result or halt pulses out
    mem_finish = 3'd3,
    // external bus granted
    ext_bus    = 3'd4
  } ctl_state_t;

endpackage

// ==== dispatch_ctl.sv ====
module dispatch_ctl (
  input  logic                                      clk,
  input  logic                                      ext_rst_e,
  input  logic                                      ext_bus_q,
  input  logic                                      ext_cpu_e,
  input  logic                                      read_q,
  input  logic                                      write_q,
  input  logic                                      mem_done,
  input  logic [cpu_dispatch_pkg::cpu_msg_size-1:0] cpu_msg_in,
  output logic                                      ext_bus_allow,
  output logic                                      ext_cpu_q,
  output logic                                      sched_step,
  output logic                                      msg_start,
  output logic                                      msg_end,
  output logic                                      mem_start_rd,
  output logic                                      mem_start_wr
);

  import cpu_dispatch_pkg::*;

  ctl_state_t state;
  ctl_state_t state_nxt;

  // next state and the one-cycle command pulses
  always_comb begin
    state_nxt    = state;
    sched_step   = 1'b0;
    msg_start    = 1'b0;
    msg_end      = 1'b0;
    mem_start_rd = 1'b0;
    mem_start_wr = 1'b0;

    case (state)
      loop: begin
        // bus request wins over polling
        if (ext_bus_q) begin
          state_nxt = ext_bus;
        end else if (!ext_cpu_e) begin
          // scheduler loads the new index on this edge
          sched_step = 1'b1;
          state_nxt  = cpu_cmd;
        end
      end

      cpu_cmd: begin
        // read, then write, then message
        if (read_q) begin
          mem_start_rd = 1'b1;
          state_nxt    = mem_work;
        end else if (write_q) begin
          mem_start_wr = 1'b1;
          state_nxt    = mem_work;
        end else if (ext_cpu_e) begin
          // unknown codes just end the poll
          msg_start = (cpu_msg_in == cpu_r_start);
          msg_end   = (cpu_msg_in == cpu_r_end);
          state_nxt = loop;
        end
        // no limit on how long the cpu takes
      end

      mem_work: begin
        // done, halt or timeout all end here
        if (mem_done) begin
          state_nxt = mem_finish;
        end
      end

      mem_finish: begin
        // proxy shows result pulses during this cycle
        state_nxt = loop;
      end

      ext_bus: begin
        if (!ext_bus_q) begin
          state_nxt = loop;
        end
      end

      default: begin
        state_nxt = loop;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state         <= loop;
      ext_cpu_q     <= 1'b0;
      ext_bus_allow <= 1'b0;
    end else begin
      state     <= state_nxt;
      // poll strobe lines up with the fresh index
      ext_cpu_q <= sched_step;
      // grant follows the request one edge late, drops one edge late
      ext_bus_allow <= (state == ext_bus) && ext_bus_q;
    end
  end

endmodule

// ==== cpu_scheduler.sv ====
module cpu_scheduler #(
  parameter int cpu_quantity = 4
) (
  input  logic                                   clk,
  input  logic                                   ext_rst_e,
  input  logic                                   sched_step,
  input  logic                                   msg_start,
  input  logic                                   msg_end,
  output logic [cpu_dispatch_pkg::data_size-1:0] ext_cpu_index
);

  import cpu_dispatch_pkg::*;

  // counters hold 0 .. cpu_quantity
  localparam int cnt_w = $clog2(cpu_quantity + 1);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(cpu_quantity);

  logic [cnt_w-1:0]     cpu_num;
  logic [cnt_w-1:0]     cnt_active;
  logic [cnt_w-1:0]     cnt_idle;
  logic                 last_wake;
  logic                 take_wake;
  logic                 num_wrap;
  logic [cnt_w-1:0]     num_next;
  logic [data_size-1:0] index_next;

  always_comb begin
    // wake slot only if someone is idle and the last pick was not one
    take_wake  = (cnt_idle != '0) && !last_wake;
    // wrap after active-1, stay at 0 with nobody active
    num_wrap   = (cnt_active == '0) || (cpu_num >= cnt_active - 1'b1);
    num_next   = num_wrap ? '0 : cpu_num + 1'b1;
    index_next = '0;
    if (take_wake) begin
      index_next[cpu_nonactive_bit] = 1'b1;
    end else begin
      index_next[cnt_w-1:0]      = num_next;
      index_next[cpu_active_bit] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      ext_cpu_index <= '0;
      cpu_num       <= '0;
      cnt_active    <= '0;
      cnt_idle      <= cnt_max;
      last_wake     <= 1'b0;
    end else begin
      if (sched_step) begin
        ext_cpu_index <= index_next;
        last_wake     <= take_wake;
        // number only moves on an active pick
        if (!take_wake) begin
          cpu_num <= num_next;
        end
      end

      // saturating accounting
      if (msg_start) begin
        if (cnt_active != cnt_max) begin
          cnt_active <= cnt_active + 1'b1;
        end
        if (cnt_idle != '0) begin
          cnt_idle <= cnt_idle - 1'b1;
        end
      end else if (msg_end) begin
        if (cnt_active != '0) begin
          cnt_active <= cnt_active - 1'b1;
        end
        if (cnt_idle != cnt_max) begin
          cnt_idle <= cnt_idle + 1'b1;
        end
      end
    end
  end

endmodule

// ==== mem_access_ctl.sv ====
module mem_access_ctl #(
  parameter int mem_timeout_cycles = cpu_dispatch_pkg::mem_timeout_default
) (
  input  logic                                   clk,
  input  logic                                   ext_rst_e,
  input  logic                                   mem_start_rd,
  input  logic                                   mem_start_wr,
  input  logic                                   rw_halt_in,
  input  logic                                   ext_rw_halt_in,
  input  logic                                   ext_read_dn,
  input  logic                                   ext_write_dn,
  input  logic [cpu_dispatch_pkg::addr_size-1:0] addr_in,
  input  logic [cpu_dispatch_pkg::addr_size-1:0] ext_mem_addr_in,
  input  logic [cpu_dispatch_pkg::data_size-1:0] data_in,
  input  logic [cpu_dispatch_pkg::data_size-1:0] ext_mem_data_in,
  output logic                                   mem_done,
  output logic                                   ext_read_q,
  output logic                                   ext_write_q,
  output logic                                   read_dn,
  output logic                                   write_dn,
  output logic                                   rw_halt_out,
  output logic                                   ext_rw_halt_out,
  output logic [cpu_dispatch_pkg::addr_size-1:0] addr_out,
  output logic [cpu_dispatch_pkg::addr_size-1:0] ext_mem_addr_out,
  output logic [cpu_dispatch_pkg::data_size-1:0] data_out,
  output logic [cpu_dispatch_pkg::data_size-1:0] ext_mem_data_out
);

  import cpu_dispatch_pkg::*;

  // counter reaches limit+1 at most
  localparam int wait_w = $clog2(mem_timeout_cycles + 2);
  localparam logic [wait_w-1:0] wait_limit = wait_w'(mem_timeout_cycles);

  logic              busy;
  logic              op_is_wr;
  logic [wait_w-1:0] wait_cnt;
  logic              timed_out;
  logic              rd_done;
  logic              wr_done;

  always_comb begin
    timed_out = wait_cnt > wait_limit;
    rd_done   = !op_is_wr && ext_read_dn;
    wr_done   = op_is_wr && ext_write_dn;
    // every way out of the wait counts as the end of the operation
    mem_done  = busy && (rw_halt_in || ext_rw_halt_in || timed_out || rd_done || wr_done);
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      busy             <= 1'b0;
      op_is_wr         <= 1'b0;
      wait_cnt         <= '0;
      ext_read_q       <= 1'b0;
      ext_write_q      <= 1'b0;
      read_dn          <= 1'b0;
      write_dn         <= 1'b0;
      rw_halt_out      <= 1'b0;
      ext_rw_halt_out  <= 1'b0;
      addr_out         <= '0;
      data_out         <= '0;
      ext_mem_addr_out <= '0;
      ext_mem_data_out <= '0;
    end else begin
      // all pulses and result words last one cycle
      ext_read_q      <= 1'b0;
      ext_write_q     <= 1'b0;
      read_dn         <= 1'b0;
      write_dn        <= 1'b0;
      rw_halt_out     <= 1'b0;
      ext_rw_halt_out <= 1'b0;
      addr_out        <= '0;
      data_out        <= '0;

      if (!busy) begin
        if (mem_start_rd || mem_start_wr) begin
          // read wins if both ever show up
          busy             <= 1'b1;
          op_is_wr         <= !mem_start_rd;
          wait_cnt         <= '0;
          ext_read_q       <= mem_start_rd;
          ext_write_q      <= !mem_start_rd;
          ext_mem_addr_out <= addr_in;
          ext_mem_data_out <= mem_start_rd ? '0 : data_in;
        end
      end else if (mem_done) begin
        busy             <= 1'b0;
        wait_cnt         <= '0;
        ext_mem_addr_out <= '0;
        ext_mem_data_out <= '0;
        // cpu halt goes out to memory side
        if (rw_halt_in) begin
          ext_rw_halt_out <= 1'b1;
        // memory halt goes back to the cpu
        end else if (ext_rw_halt_in) begin
          rw_halt_out <= 1'b1;
        // silent memory halts both sides
        end else if (timed_out) begin
          rw_halt_out     <= 1'b1;
          ext_rw_halt_out <= 1'b1;
        end else begin
          read_dn  <= rd_done;
          write_dn <= wr_done;
          addr_out <= ext_mem_addr_in;
          data_out <= ext_mem_data_in;
        end
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== cpu_dispatcher.sv ====
module cpu_dispatcher #(
  parameter int cpu_quantity       = 4,
  parameter int mem_timeout_cycles = cpu_dispatch_pkg::mem_timeout_default
) (
  input  logic                                     clk,
  input  logic                                     ext_rst_e,

  // external bus request and grant
  input  logic                                     ext_bus_q,
  output logic                                     ext_bus_allow,

  // cpu poll side
  output logic                                     ext_cpu_q,
  input  logic                                     ext_cpu_e,
  output logic [cpu_dispatch_pkg::data_size-1:0]   ext_cpu_index,
  input  logic [cpu_dispatch_pkg::cpu_msg_size-1:0] cpu_msg_in,

  // cpu memory requests
  input  logic                                     read_q,
  input  logic                                     write_q,
  output logic                                     read_dn,
  output logic                                     write_dn,
  input  logic [cpu_dispatch_pkg::addr_size-1:0]   addr_in,
  output logic [cpu_dispatch_pkg::addr_size-1:0]   addr_out,
  input  logic [cpu_dispatch_pkg::data_size-1:0]   data_in,
  output logic [cpu_dispatch_pkg::data_size-1:0]   data_out,

  // halt in both directions
  input  logic                                     rw_halt_in,
  output logic                                     rw_halt_out,
  input  logic                                     ext_rw_halt_in,
  output logic                                     ext_rw_halt_out,

  // external memory side
  output logic                                     ext_read_q,
  output logic                                     ext_write_q,
  input  logic                                     ext_read_dn,
  input  logic                                     ext_write_dn,
  input  logic [cpu_dispatch_pkg::addr_size-1:0]   ext_mem_addr_in,
  output logic [cpu_dispatch_pkg::addr_size-1:0]   ext_mem_addr_out,
  input  logic [cpu_dispatch_pkg::data_size-1:0]   ext_mem_data_in,
  output logic [cpu_dispatch_pkg::data_size-1:0]   ext_mem_data_out
);

  // controller to scheduler
  logic sched_step;
  logic msg_start;
  logic msg_end;

  // controller to memory proxy and back
  logic mem_start_rd;
  logic mem_start_wr;
  logic mem_done;

  // main fsm and bus grant
  dispatch_ctl i_ctl (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .ext_bus_q     (ext_bus_q),
    .ext_cpu_e     (ext_cpu_e),
    .read_q        (read_q),
    .write_q       (write_q),
    .mem_done      (mem_done),
    .cpu_msg_in    (cpu_msg_in),
    .ext_bus_allow (ext_bus_allow),
    .ext_cpu_q     (ext_cpu_q),
    .sched_step    (sched_step),
    .msg_start     (msg_start),
    .msg_end       (msg_end),
    .mem_start_rd  (mem_start_rd),
    .mem_start_wr  (mem_start_wr)
  );

  // round robin pick and cpu accounting
  cpu_scheduler #(
    .cpu_quantity (cpu_quantity)
  ) i_sched (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .sched_step    (sched_step),
    .msg_start     (msg_start),
    .msg_end       (msg_end),
    .ext_cpu_index (ext_cpu_index)
  );

  // one memory operation at a time
  mem_access_ctl #(
    .mem_timeout_cycles (mem_timeout_cycles)
  ) i_mem (
    .clk              (clk),
    .ext_rst_e        (ext_rst_e),
    .mem_start_rd     (mem_start_rd),
    .mem_start_wr     (mem_start_wr),
    .rw_halt_in       (rw_halt_in),
    .ext_rw_halt_in   (ext_rw_halt_in),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .addr_in          (addr_in),
    .ext_mem_addr_in  (ext_mem_addr_in),
    .data_in          (data_in),
    .ext_mem_data_in  (ext_mem_data_in),
    .mem_done         (mem_done),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .read_dn          (read_dn),
    .write_dn         (write_dn),
    .rw_halt_out      (rw_halt_out),
    .ext_rw_halt_out  (ext_rw_halt_out),
    .addr_out         (addr_out),
    .ext_mem_addr_out (ext_mem_addr_out),
    .data_out         (data_out),
    .ext_mem_data_out (ext_mem_data_out)
  );

endmodule

// ==== cpu_dispatcher_props.sv ====
module cpu_dispatcher_props (
  input logic                                   clk,
  input logic                                   ext_rst_e,
  input logic                                   ext_read_q,
  input logic                                   ext_write_q,
  input logic                                   read_dn,
  input logic [cpu_dispatch_pkg::data_size-1:0] data_out,
  input logic                                   ext_bus_q,
  input logic                                   ext_bus_allow
);

  // failed property count
  int fail_cnt = 0;

  // one request kind at a time
  rw_excl: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(ext_read_q && ext_write_q))
    else begin
      fail_cnt++;
      $error("ext_read_q and ext_write_q high together");
    end

  // requests are single-cycle strobes
  rd_pulse: assert property (@(posedge clk) disable iff (ext_rst_e)
    ext_read_q |=> !ext_read_q)
    else begin
      fail_cnt++;
      $error("ext_read_q longer than one cycle");
    end

  wr_pulse: assert property (@(posedge clk) disable iff (ext_rst_e)
    ext_write_q |=> !ext_write_q)
    else begin
      fail_cnt++;
      $error("ext_write_q longer than one cycle");
    end

  // result word clears right after the done pulse
  rd_clear: assert property (@(posedge clk) disable iff (ext_rst_e)
    read_dn |=> (data_out == '0))
    else begin
      fail_cnt++;
      $error("data_out not cleared after read_dn");
    end

  // grant only follows a request
  bus_grant: assert property (@(posedge clk) disable iff (ext_rst_e)
    ext_bus_allow |-> $past(ext_bus_q))
    else begin
      fail_cnt++;
      $error("ext_bus_allow without ext_bus_q");
    end

endmodule

bind cpu_dispatcher cpu_dispatcher_props i_props (
  .clk           (clk),
  .ext_rst_e     (ext_rst_e),
  .ext_read_q    (ext_read_q),
  .ext_write_q   (ext_write_q),
  .read_dn       (read_dn),
  .data_out      (data_out),
  .ext_bus_q     (ext_bus_q),
  .ext_bus_allow (ext_bus_allow)
);

// ==== tb_cpu_dispatcher.sv ====
module tb_cpu_dispatcher;

  import cpu_dispatch_pkg::*;

  localparam int cpus        = 4;
  localparam int mem_timeout = 50;
  localparam int case_cycles = 400;

  logic                    clk = 1'b0;
  logic                    ext_rst_e;
  logic                    ext_bus_q;
  logic                    ext_cpu_e;
  logic                    read_q;
  logic                    write_q;
  logic                    rw_halt_in;
  logic                    ext_rw_halt_in;
  logic                    ext_read_dn;
  logic                    ext_write_dn;
  logic [cpu_msg_size-1:0] cpu_msg_in;
  logic [addr_size-1:0]    addr_in;
  logic [addr_size-1:0]    ext_mem_addr_in;
  logic [data_size-1:0]    data_in;
  logic [data_size-1:0]    ext_mem_data_in;
  logic                    ext_bus_allow;
  logic                    ext_cpu_q;
  logic                    read_dn;
  logic                    write_dn;
  logic                    rw_halt_out;
  logic                    ext_rw_halt_out;
  logic                    ext_read_q;
  logic                    ext_write_q;
  logic [data_size-1:0]    ext_cpu_index;
  logic [data_size-1:0]    data_out;
  logic [data_size-1:0]    ext_mem_data_out;
  logic [addr_size-1:0]    addr_out;
  logic [addr_size-1:0]    ext_mem_addr_out;

  // case table
  string       kinds[$];
  logic [31:0] c_op[$];
  logic [31:0] c_addr[$];
  logic [31:0] c_data[$];
  logic [31:0] c_idx[$];

  int errors      = 0;
  int cases_ok    = 0;
  int cases_bad   = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  // reference copy of the scheduler counts
  int m_num;
  int m_active;
  int m_idle;
  bit m_last_wake;

  cpu_dispatcher #(
    .cpu_quantity       (cpus),
    .mem_timeout_cycles (mem_timeout)
  ) i_dut (
    .clk (clk), .ext_rst_e (ext_rst_e),
    .ext_bus_q (ext_bus_q), .ext_bus_allow (ext_bus_allow),
    .ext_cpu_q (ext_cpu_q), .ext_cpu_e (ext_cpu_e),
    .ext_cpu_index (ext_cpu_index), .cpu_msg_in (cpu_msg_in),
    .read_q (read_q), .write_q (write_q), .read_dn (read_dn), .write_dn (write_dn),
    .addr_in (addr_in), .addr_out (addr_out), .data_in (data_in), .data_out (data_out),
    .rw_halt_in (rw_halt_in), .rw_halt_out (rw_halt_out),
    .ext_rw_halt_in (ext_rw_halt_in), .ext_rw_halt_out (ext_rw_halt_out),
    .ext_read_q (ext_read_q), .ext_write_q (ext_write_q),
    .ext_read_dn (ext_read_dn), .ext_write_dn (ext_write_dn),
    .ext_mem_addr_in (ext_mem_addr_in), .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_in (ext_mem_data_in), .ext_mem_data_out (ext_mem_data_out)
  );

  always #5 clk = ~clk;

  // run guard with its limit set once the cases are loaded
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("run stopped after %0d cycles, the DUT stopped answering", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  // wake slot when someone idles and the last pick was no wake
  task automatic predict_index(output logic [31:0] idx);
    idx = '0;
    if (m_idle > 0 && !m_last_wake) begin
      idx[cpu_nonactive_bit] = 1'b1;
      m_last_wake = 1'b1;
    end else begin
      if (m_active == 0 || m_num >= m_active - 1)
        m_num = 0;
      else
        m_num = m_num + 1;
      idx = 32'(m_num);
      idx[cpu_active_bit] = 1'b1;
      m_last_wake = 1'b0;
    end
  endtask

  task automatic apply_msg(input logic [31:0] msg);
    if (msg[7:0] == cpu_r_start) begin
      if (m_active < cpus) m_active++;
      if (m_idle > 0) m_idle--;
    end else if (msg[7:0] == cpu_r_end) begin
      if (m_active > 0) m_active--;
      if (m_idle < cpus) m_idle++;
    end
  endtask

  task automatic do_reset();
    ext_rst_e <= 1'b1;
    repeat (10) @(posedge clk);
    ext_rst_e <= 1'b0;
    m_num = 0;
    m_active = 0;
    m_idle = cpus;
    m_last_wake = 1'b0;
    // outputs still hold reset values until the next edge
    @(negedge clk);
    check_val("ext_bus_allow", ext_bus_allow, 0);
    check_val("ext_cpu_q", ext_cpu_q, 0);
    check_val("ext_read_q", ext_read_q, 0);
    check_val("ext_write_q", ext_write_q, 0);
    check_val("read_dn", read_dn, 0);
    check_val("write_dn", write_dn, 0);
    check_val("rw_halt_out", rw_halt_out, 0);
    check_val("ext_rw_halt_out", ext_rw_halt_out, 0);
    check_val("ext_cpu_index", ext_cpu_index, 0);
  endtask

  // wait for the poll strobe and compare the index with model and table
  task automatic wait_poll(input logic [31:0] exp_idx);
    logic [31:0] model_idx;
    @(negedge clk);
    while (ext_cpu_q !== 1'b1) @(negedge clk);
    predict_index(model_idx);
    check_val("case table index vs model", exp_idx, model_idx);
    check_val("ext_cpu_index", ext_cpu_index, model_idx);
  endtask

  task automatic answer_poll(input logic [31:0] msg, input logic bus);
    @(posedge clk);
    ext_cpu_e  <= 1'b1;
    cpu_msg_in <= msg[7:0];
    ext_bus_q  <= bus;
    @(posedge clk);
    ext_cpu_e  <= 1'b0;
    cpu_msg_in <= '0;
    apply_msg(msg);
  endtask

  // polled cpu asks for memory and the forwarded request is checked
  task automatic start_mem(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    read_q  <= !wr;
    write_q <= wr;
    addr_in <= addr;
    data_in <= data;
    @(posedge clk);
    read_q  <= 1'b0;
    write_q <= 1'b0;
    @(negedge clk);
    check_val("ext_read_q", ext_read_q, !wr);
    check_val("ext_write_q", ext_write_q, wr);
    check_val("ext_mem_addr_out", ext_mem_addr_out, addr);
    if (wr) check_val("ext_mem_data_out", ext_mem_data_out, data);
  endtask

  task automatic mem_answer(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    repeat ($urandom_range(10, 0)) @(posedge clk);
    @(posedge clk);
    ext_read_dn     <= !wr;
    ext_write_dn    <= wr;
    ext_mem_addr_in <= addr;
    ext_mem_data_in <= data;
    @(posedge clk);
    ext_read_dn  <= 1'b0;
    ext_write_dn <= 1'b0;
    @(negedge clk);
    while (read_dn !== 1'b1 && write_dn !== 1'b1) @(negedge clk);
    check_val("read_dn", read_dn, !wr);
    check_val("write_dn", write_dn, wr);
    check_val("data_out", data_out, data);
    check_val("addr_out", addr_out, addr);
    @(negedge clk);
    check_val("data_out after done", data_out, 0);
    check_val("addr_out after done", addr_out, 0);
  endtask

  // one-cycle halt from either side answered only by the opposite output
  task automatic halt_test(input logic from_cpu);
    repeat ($urandom_range(10, 0)) @(posedge clk);
    @(posedge clk);
    rw_halt_in     <= from_cpu;
    ext_rw_halt_in <= !from_cpu;
    @(posedge clk);
    rw_halt_in     <= 1'b0;
    ext_rw_halt_in <= 1'b0;
    @(negedge clk);
    while (rw_halt_out !== 1'b1 && ext_rw_halt_out !== 1'b1) @(negedge clk);
    check_val("ext_rw_halt_out", ext_rw_halt_out, from_cpu);
    check_val("rw_halt_out", rw_halt_out, !from_cpu);
    check_val("read_dn", read_dn, 0);
  endtask

  task automatic timeout_test();
    int n;
    n = 0;
    while (rw_halt_out !== 1'b1 && ext_rw_halt_out !== 1'b1) begin
      @(negedge clk);
      n++;
    end
    check_val("rw_halt_out", rw_halt_out, 1);
    check_val("ext_rw_halt_out", ext_rw_halt_out, 1);
    assert (n >= mem_timeout + 1 && n <= mem_timeout + 3) else begin
      $display("memory timeout fired after %0d cycles, outside the allowed window", n);
      errors++;
    end
  endtask

  task automatic bus_test();
    int hold;
    hold = $urandom_range(10, 3);
    // ext_bus_q already raised with the poll answer
    @(negedge clk);
    while (ext_bus_allow !== 1'b1) begin
      check_val("ext_cpu_q while bus wanted", ext_cpu_q, 0);
      @(negedge clk);
    end
    repeat (hold) begin
      @(negedge clk);
      check_val("ext_bus_allow", ext_bus_allow, 1);
      check_val("ext_cpu_q during grant", ext_cpu_q, 0);
    end
    @(posedge clk);
    ext_bus_q <= 1'b0;
    @(negedge clk);
    @(negedge clk);
    check_val("ext_bus_allow after release", ext_bus_allow, 0);
  endtask

  task automatic run_case(input int i);
    int err0;
    err0 = errors;
    case (kinds[i])
      "reset": do_reset();
      "poll": begin
        wait_poll(c_idx[i]);
        answer_poll(c_op[i], 1'b0);
      end
      "read", "write": begin
        wait_poll(c_idx[i]);
        start_mem(kinds[i] == "write", c_addr[i], c_data[i]);
        mem_answer(kinds[i] == "write", c_addr[i], c_data[i]);
      end
      "tmo", "hcpu", "hmem": begin
        wait_poll(c_idx[i]);
        start_mem(c_op[i][0], c_addr[i], c_data[i]);
        if (kinds[i] == "tmo") timeout_test();
        else halt_test(kinds[i] == "hcpu");
      end
      "bus": begin
        wait_poll(c_idx[i]);
        answer_poll(c_op[i], 1'b1);
        bus_test();
      end
      default: begin
        $display("case %0d has unknown kind %s", i, kinds[i]);
        errors++;
      end
    endcase
    if (errors == err0) begin
      cases_ok++;
      $display("case %0d %s ok", i, kinds[i]);
    end else begin
      cases_bad++;
      $display("case %0d %s failed", i, kinds[i]);
    end
  endtask

  task automatic load_cases(input int fd);
    string       line;
    string       k;
    logic [31:0] a, b, c, d;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // comment lines start with #
      if (line.len() > 0 && line[0] != "#") begin
        if ($sscanf(line, "%s %h %h %h %h", k, a, b, c, d) == 5) begin
          kinds.push_back(k);
          c_op.push_back(a);
          c_addr.push_back(b);
          c_data.push_back(c);
          c_idx.push_back(d);
        end
      end
    end
  endtask

  initial begin
    int fd;
    int seed_val;
    seed_val = $urandom(19739);
    ext_rst_e       <= 1'b1;
    ext_bus_q       <= 1'b0;
    ext_cpu_e       <= 1'b0;
    read_q          <= 1'b0;
    write_q         <= 1'b0;
    rw_halt_in      <= 1'b0;
    ext_rw_halt_in  <= 1'b0;
    ext_read_dn     <= 1'b0;
    ext_write_dn    <= 1'b0;
    cpu_msg_in      <= '0;
    addr_in         <= '0;
    data_in         <= '0;
    ext_mem_addr_in <= '0;
    ext_mem_data_in <= '0;
    fd = $fopen("dispatcher_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open dispatcher_cases.txt");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      load_cases(fd);
      $fclose(fd);
      cycle_limit = case_cycles * kinds.size();
      for (int i = 0; i < kinds.size(); i++) run_case(i);
      $display("cases passed %0d, failed %0d, check errors %0d, property failures %0d",
               cases_ok, cases_bad, errors, i_dut.i_props.fail_cnt);
      if (errors == 0 && cases_bad == 0 && kinds.size() > 0 &&
          i_dut.i_props.fail_cnt == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

// ==== dispatcher_cases.txt ====
# kind  op/msg  addr  data  expected_index, all hex
# msg 01 start, 02 end, 00 none; op for tmo/hcpu/hmem 0 read, 1 write
reset 00 00000000 00000000 00000000
poll 01 00000000 00000000 40000000
poll 01 00000000 00000000 80000000
poll 01 00000000 00000000 40000000
poll 01 00000000 00000000 80000001
poll 00 00000000 00000000 80000002
poll 02 00000000 00000000 80000003
poll 00 00000000 00000000 40000000
read 00 00001000 cafe0001 80000000
write 00 00002004 12345678 40000000
tmo 00 00003000 00000000 80000001
hcpu 00 00004000 00000000 40000000
hmem 01 00005008 a5a5a5a5 80000002
bus 00 00000000 00000000 40000000
poll 00 00000000 00000000 80000000
read 00 0000100c 0badf00d 40000000
write 00 00002010 87654321 80000001
poll 02 00000000 00000000 40000000
poll 02 00000000 00000000 80000000
poll 01 00000000 00000000 40000000
bus 00 00000000 00000000 80000001
poll 00 00000000 00000000 40000000
tmo 01 00003004 deadbeef 80000000

// ==== build.f ====
cpu_dispatch_pkg.sv
dispatch_ctl.sv
cpu_scheduler.sv
mem_access_ctl.sv
cpu_dispatcher.sv
cpu_dispatcher_props.sv
tb_cpu_dispatcher.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu_dispatcher
FILELIST = build.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
